// File: logic/arcade_input_defs.svh
`ifndef ARCADE_INPUT_DEFS_SVH
`define ARCADE_INPUT_DEFS_SVH

// ==================================================
// Keyboard scan codes (set 2, make codes)
// ==================================================
`define KEY_UP    8'h75  // Cursor up
`define KEY_DOWN  8'h72  // Cursor down
`define KEY_LEFT  8'h6B  // Cursor left
`define KEY_RIGHT 8'h74  // Cursor right
`define KEY_COIN  8'h76  // ESC
`define KEY_P1    8'h05  // F1
`define KEY_P2    8'h06  // F2
`define KEY_FIRE  8'h29  // Space

// Key event word layout
`define PS2_PRESSED 9
`define PS2_TOGGLE  10

// Host status and button bits
`define STAT_RESET      0
`define STAT_ROTATE     2   // High means directions unrotated
`define STAT_SOFT_RESET 6
`define BTN_RESET       1

// Joystick bit layout
`define JOY_RIGHT 0
`define JOY_LEFT  1
`define JOY_DOWN  2
`define JOY_UP    3
`define JOY_FIRE  4

`endif

// File: logic/arcade_input_pkg.sv
package arcade_input_pkg;

	// ==================================================
	// Plain vector types
	// ==================================================

	// Key event word from the host I/O controller
	// Bit 10 toggles per event, bit 9 is pressed, 7:0 the scan code
	typedef logic [10:0] ps2_key_t;

	typedef logic [7:0] scan_code_t;

	// One joystick with bits 4:0 as fire, up, down, left and right
	typedef logic [7:0] joy_t;

	typedef logic [31:0] status_t;     // Host option word

	typedef logic [7:0] port_byte_t;   // Active-low cabinet byte

	// ==================================================
	// Grouped control levels
	// ==================================================

	// Held keyboard levels, one bit per recognised key
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic one_player;
		logic two_players;
		logic fire;
	} key_buttons_t;

	// Merged player controls after rotation, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic one_player;
		logic two_players;
		logic fire;
	} player_ctrl_t;

endpackage

// File: logic/key_event_decoder.sv
`timescale 1ns/1ns
`include "arcade_input_defs.svh"

module key_event_decoder import arcade_input_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  ps2_key_t     ps2_key,
	output key_buttons_t buttons_out
);

	ps2_key_t   key_q;        // Key word one clock behind the host
	logic       toggle_prev;  // Toggle as seen one clock before key_q
	logic       key_event;
	logic       pressed;
	scan_code_t code;

	// ==================================================
	// Event detection
	// ==================================================

	// Input stage plus toggle history
	always_ff @(posedge clk_sys) begin
		key_q       <= ps2_key;
		toggle_prev <= key_q[`PS2_TOGGLE];
	end

	// Any edge on the toggle marks a new event
	assign key_event = key_q[`PS2_TOGGLE] != toggle_prev;

	assign pressed = key_q[`PS2_PRESSED];
	assign code    = key_q[7:0];  // Scan code field

	// ==================================================
	// Held key levels
	// ==================================================

	// Press sets and release clears, two clocks after the toggle moves
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			buttons_out <= '0;
		end else if (key_event) begin
			case (code)
				`KEY_UP: begin
					buttons_out.up <= pressed;
				end
				`KEY_DOWN: begin
					buttons_out.down <= pressed;
				end
				`KEY_LEFT: begin
					buttons_out.left <= pressed;
				end
				`KEY_RIGHT: begin
					buttons_out.right <= pressed;
				end
				`KEY_COIN: begin
					buttons_out.coin <= pressed;
				end
				`KEY_P1: begin
					buttons_out.one_player <= pressed;
				end
				`KEY_P2: begin
					buttons_out.two_players <= pressed;
				end
				`KEY_FIRE: begin
					buttons_out.fire <= pressed;
				end
				default: begin
					// Unknown codes leave every level alone
				end
			endcase
		end
	end

endmodule

// File: logic/control_merger.sv
`timescale 1ns/1ns
`include "arcade_input_defs.svh"

module control_merger import arcade_input_pkg::*; (
	input  key_buttons_t kbd,
	input  joy_t         joystick_0,
	input  joy_t         joystick_1,
	input  logic         rotate,      // High passes directions straight
	output player_ctrl_t ctrl
);

	// Per-source OR, before rotation
	logic any_up;
	logic any_down;
	logic any_left;
	logic any_right;
	logic any_fire;

	// ==================================================
	// Keyboard and joystick merge
	// ==================================================

	// Each control stays active until all three sources release it
	assign any_up    = kbd.up    | joystick_0[`JOY_UP]    | joystick_1[`JOY_UP];
	assign any_down  = kbd.down  | joystick_0[`JOY_DOWN]  | joystick_1[`JOY_DOWN];
	assign any_left  = kbd.left  | joystick_0[`JOY_LEFT]  | joystick_1[`JOY_LEFT];
	assign any_right = kbd.right | joystick_0[`JOY_RIGHT] | joystick_1[`JOY_RIGHT];
	assign any_fire  = kbd.fire  | joystick_0[`JOY_FIRE]  | joystick_1[`JOY_FIRE];

	// ==================================================
	// Rotation select
	// ==================================================

	always_comb begin
		if (rotate) begin
			ctrl.up    = any_up;
			ctrl.down  = any_down;
			ctrl.left  = any_left;
			ctrl.right = any_right;
		end else begin
			// Cabinet turned a quarter, so directions shift round
			ctrl.up    = any_left;
			ctrl.down  = any_right;
			ctrl.left  = any_down;
			ctrl.right = any_up;
		end

		ctrl.fire = any_fire;

		// Keyboard only
		ctrl.coin        = kbd.coin;
		ctrl.one_player  = kbd.one_player;
		ctrl.two_players = kbd.two_players;
	end

endmodule

// File: logic/cabinet_port_encoder.sv
`timescale 1ns/1ns
`include "arcade_input_defs.svh"

module cabinet_port_encoder import arcade_input_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  player_ctrl_t ctrl,
	input  status_t      status,
	input  logic [1:0]   buttons,
	output port_byte_t   in0_reg,
	output port_byte_t   in1_reg,
	output logic         game_reset
);

	port_byte_t in0_next;
	port_byte_t in1_next;
	logic       reset_req;

	// ==================================================
	// Active-low port byte layout
	// ==================================================

	// IN0 from bit 7 is 0 0 coin 0 down right left up
	assign in0_next = ~{2'b00, ctrl.coin, 1'b0,
		ctrl.down, ctrl.right, ctrl.left, ctrl.up};

	// IN1 from bit 7 is 0 two_players one_player fire 0000
	assign in1_next = ~{1'b0, ctrl.two_players, ctrl.one_player,
		ctrl.fire, 4'b0000};

	// Host reset, menu reset entry and the reset button
	assign reset_req = status[`STAT_RESET] | status[`STAT_SOFT_RESET] |
		buttons[`BTN_RESET];

	// ==================================================
	// Output register
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			in0_reg    <= 8'hFF;  // Idle with nothing pressed
			in1_reg    <= 8'hFF;
			game_reset <= 1'b0;
		end else begin
			in0_reg    <= in0_next;
			in1_reg    <= in1_next;
			game_reset <= reset_req;
		end
	end

endmodule

// File: logic/arcade_input_top.sv
`timescale 1ns/1ns
`include "arcade_input_defs.svh"

module arcade_input_top import arcade_input_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  ps2_key_t   ps2_key,     // Toggle-strobed key events
	input  joy_t       joystick_0,
	input  joy_t       joystick_1,
	input  status_t    status,
	input  logic [1:0] buttons,
	output port_byte_t in0_reg,
	output port_byte_t in1_reg,
	output logic       game_reset
);

	key_buttons_t kbd_buttons;  // Held keyboard levels
	player_ctrl_t player_ctrl;  // After merge and rotation

	// ==================================================
	// Decode, execute, result
	// ==================================================

	key_event_decoder key_event_decoder_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ps2_key     (ps2_key),
		.buttons_out (kbd_buttons)
	);

	// Combinational merge with no added latency
	control_merger control_merger_inst (
		.kbd        (kbd_buttons),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (status[`STAT_ROTATE]),
		.ctrl       (player_ctrl)
	);

	cabinet_port_encoder cabinet_port_encoder_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ctrl       (player_ctrl),
		.status     (status),
		.buttons    (buttons),
		.in0_reg    (in0_reg),
		.in1_reg    (in1_reg),
		.game_reset (game_reset)
	);

endmodule

// File: tb/arcade_input_tb.sv
`timescale 1ns/1ns

module arcade_input_tb import arcade_input_pkg::*; ();

	localparam string VECTOR_FILE = "tb/arcade_input_vectors.txt";
	localparam int    MAX_LINES   = 1000;  // Upper bound on lines read
	localparam int    MIN_STEPS   = 10;    // Fewer means a truncated file

	logic       clk_sys;
	logic       reset;
	ps2_key_t   ps2_key;
	joy_t       joystick_0;
	joy_t       joystick_1;
	status_t    status;
	logic [1:0] buttons;
	port_byte_t in0_reg;
	port_byte_t in1_reg;
	logic       game_reset;

	arcade_input_top arcade_input_top_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ps2_key    (ps2_key),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.buttons    (buttons),
		.in0_reg    (in0_reg),
		.in1_reg    (in1_reg),
		.game_reset (game_reset)
	);

	// ==================================================
	// Clock with 8 ns period
	// ==================================================

	initial begin
		clk_sys = 1'b0;
	end

	always begin
		#4 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Helpers
	// ==================================================

	// Print the reason, then end the run
	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_value(
		input string       test_name,
		input string       signal_name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		if (actual !== expected) begin
			fail_run($sformatf("[FAIL] %s: %s expected %0h, actual %0h",
				test_name, signal_name, expected, actual));
		end
	endtask

	// Bounded wait on falling edges
	task automatic wait_falling_edges(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic check_outputs(
		input string      test_name,
		input port_byte_t exp_in0,
		input port_byte_t exp_in1,
		input logic       exp_reset
	);
		check_value(test_name, "in0_reg", {24'h0, exp_in0}, {24'h0, in0_reg});
		check_value(test_name, "in1_reg", {24'h0, exp_in1}, {24'h0, in1_reg});
		check_value(test_name, "game_reset", {31'h0, exp_reset}, {31'h0, game_reset});
	endtask

	// ==================================================
	// Stimulus from the vector file
	// ==================================================

	initial begin
		int         fd;
		int         line_count;
		int         step_count;
		int         fields;
		bit         at_end;
		string      line;
		string      test_name;
		ps2_key_t   v_key;
		joy_t       v_joy0;
		joy_t       v_joy1;
		status_t    v_status;
		logic [1:0] v_buttons;
		port_byte_t v_in0;
		port_byte_t v_in1;
		logic       v_reset;

		line_count  = 0;
		step_count  = 0;
		at_end      = 1'b0;

		reset      = 1'b1;
		ps2_key    = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		status     = '0;
		buttons    = '0;

		// Reset held four cycles and released on a falling edge
		for (int i = 0; i < 4; i++) begin
			@(posedge clk_sys);
		end
		@(negedge clk_sys);
		reset = 1'b0;
		check_outputs("reset_state", 8'hFF, 8'hFF, 1'b0);

		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0) begin
			fail_run("Error: the vector file tb/arcade_input_vectors.txt cannot be opened");
		end

		while (!at_end) begin
			line_count++;
			if (line_count > MAX_LINES) begin
				fail_run("Error: the vector file has more lines than the reader allows");
			end
			line = "";
			if ($fgets(line, fd) == 0) begin
				at_end = 1'b1;
			end else if (line.len() == 0 || line[0] == "#") begin
				// Comment line
			end else begin
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h %s",
					v_key, v_joy0, v_joy1, v_status, v_buttons,
					v_in0, v_in1, v_reset, test_name);
				if (fields > 0) begin
					if (fields != 9) begin
						fail_run($sformatf(
							"Error: line %0d of the vector file holds %0d of 9 fields",
							line_count, fields));
					end
					ps2_key    = v_key;  // Driven on the falling edge
					joystick_0 = v_joy0;
					joystick_1 = v_joy1;
					status     = v_status;
					buttons    = v_buttons;
					wait_falling_edges(4);  // Covers the 3-clock key path
					check_outputs(test_name, v_in0, v_in1, v_reset);
					step_count++;
				end
			end
		end
		$fclose(fd);

		if (step_count < MIN_STEPS) begin
			fail_run($sformatf("Error: the vector file holds only %0d steps", step_count));
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: tb/arcade_input_vectors.txt
# ps2_key joy0 joy1 status buttons in0 in1 game_reset name
# ps2_key bit 10 toggles per event, bit 9 is pressed; status bit 2 high is straight
000 00 00 00000004 0 FF FF 0 reset_idle
# Key press and release, straight wiring
675 00 00 00000004 0 FE FF 0 up_press
075 00 00 00000004 0 FF FF 0 up_release
672 00 00 00000004 0 F7 FF 0 down_press
072 00 00 00000004 0 FF FF 0 down_release
66B 00 00 00000004 0 FD FF 0 left_press
06B 00 00 00000004 0 FF FF 0 left_release
674 00 00 00000004 0 FB FF 0 right_press
074 00 00 00000004 0 FF FF 0 right_release
676 00 00 00000004 0 DF FF 0 coin_press
076 00 00 00000004 0 FF FF 0 coin_release
605 00 00 00000004 0 FF DF 0 p1_press
005 00 00 00000004 0 FF FF 0 p1_release
606 00 00 00000004 0 FF BF 0 p2_press
006 00 00 00000004 0 FF FF 0 p2_release
629 00 00 00000004 0 FF EF 0 fire_press
029 00 00 00000004 0 FF FF 0 fire_release
675 00 00 00000004 0 FE FF 0 up_hold
21C 00 00 00000004 0 FE FF 0 unknown_code
475 00 00 00000004 0 FF FF 0 up_release_again
# Keyboard and both joysticks OR together
275 00 00 00000004 0 FE FF 0 up_key
275 08 00 00000004 0 FE FF 0 up_key_joy0
275 08 08 00000004 0 FE FF 0 up_all_three
475 08 08 00000004 0 FE FF 0 up_key_off
475 00 08 00000004 0 FE FF 0 up_joy0_off
475 00 00 00000004 0 FF FF 0 up_joy1_off
475 10 00 00000004 0 FF EF 0 fire_joy0
229 10 00 00000004 0 FF EF 0 fire_joy0_key
229 00 00 00000004 0 FF EF 0 fire_key_only
229 00 10 00000004 0 FF EF 0 fire_key_joy1
429 00 10 00000004 0 FF EF 0 fire_joy1_only
429 00 00 00000004 0 FF FF 0 fire_all_off
429 01 00 00000004 0 FB FF 0 joy0_right
429 00 02 00000004 0 FD FF 0 joy1_left
429 04 00 00000004 0 F7 FF 0 joy0_down
429 00 00 00000004 0 FF FF 0 joys_idle
# Rotated wiring, status bit 2 low
429 02 00 00000000 0 FE FF 0 rot_joy0_left
429 01 00 00000000 0 F7 FF 0 rot_joy0_right
429 00 04 00000000 0 FD FF 0 rot_joy1_down
429 00 08 00000000 0 FB FF 0 rot_joy1_up
26B 00 00 00000000 0 FE FF 0 rot_key_left
46B 00 00 00000000 0 FF FF 0 rot_key_left_off
275 00 00 00000000 0 FB FF 0 rot_key_up
475 00 00 00000000 0 FF FF 0 rot_key_up_off
272 00 00 00000000 0 FD FF 0 rot_key_down
472 00 00 00000000 0 FF FF 0 rot_key_down_off
274 00 00 00000000 0 F7 FF 0 rot_key_right
474 00 00 00000000 0 FF FF 0 rot_key_right_off
474 10 00 00000000 0 FF EF 0 rot_fire
# Game reset sources
474 00 00 00000005 0 FF FF 1 reset_status_bit0
474 00 00 00000044 0 FF FF 1 reset_status_bit6
474 00 00 00000004 2 FF FF 1 reset_button
474 00 00 00000004 1 FF FF 0 reset_button0_ignored
474 00 00 00000004 0 FF FF 0 reset_all_low

// File: src.f
+incdir+logic
logic/arcade_input_pkg.sv
logic/key_event_decoder.sv
logic/control_merger.sv
logic/cabinet_port_encoder.sv
logic/arcade_input_top.sv
tb/arcade_input_tb.sv

// File: Makefile
TOP := arcade_input_tb
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ns --top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
